// ==== logic/isa_pkg.sv ====
/* isa_pkg: instruction-level types shared by the issue stage,
   register indices, data words, slot identifiers and opcodes */

`default_nettype none

package isa_pkg;

    // number of functional-unit status table slots
    localparam int NSLOTS = 5;

    // scalar register index
    typedef logic [4:0] regbits_t;

    // matrix register index
    typedef logic [3:0] matbits_t;

    // data word
    typedef logic [31:0] word_t;

    // operation code handed through to execute
    typedef logic [5:0] opcode_t;

    // slot identifiers, one per functional unit
    typedef enum logic [2:0] {
        SLOT_ALU     = 3'd0,
        SLOT_LD_ST   = 3'd1,
        SLOT_BRANCH  = 3'd2,
        SLOT_M_LD_ST = 3'd3,
        SLOT_GEMM    = 3'd4
    } slot_e;

endpackage

`default_nettype wire

// ==== logic/datapath_pkg.sv ====
/* datapath_pkg: status table rows, dispatch, writeback and issue bundles
   for the scoreboard issue stage, plus the shared tag wakeup rule */

`default_nettype none

package datapath_pkg;

    // producer tag, valid clear means the operand is available
    typedef struct packed {
        logic          valid;
        isa_pkg::slot_e slot;
    } tag_t;

    // scalar status row (alu, load/store, branch)
    typedef struct packed {
        isa_pkg::opcode_t opcode;
        isa_pkg::regbits_t rd;
        isa_pkg::regbits_t rs1;
        isa_pkg::regbits_t rs2;
        tag_t             t1;
        tag_t             t2;
    } fust_s_row_t;

    // matrix status row (matrix load/store and gemm)
    // the matrix load/store row keeps ms3 and t3 at zero
    typedef struct packed {
        isa_pkg::opcode_t opcode;
        isa_pkg::matbits_t md;
        isa_pkg::matbits_t ms1;
        isa_pkg::matbits_t ms2;
        isa_pkg::matbits_t ms3;
        tag_t             t1;
        tag_t             t2;
        tag_t             t3;
    } fust_g_row_t;

    // one dispatch write, the slot picks which row contents count
    typedef struct packed {
        logic           valid;
        isa_pkg::slot_e slot;
        fust_s_row_t    s_row;
        fust_g_row_t    g_row;
    } dispatch_t;

    // writeback event, single cycle
    typedef struct packed {
        logic              valid;
        isa_pkg::slot_e    slot;
        logic              reg_en;
        isa_pkg::regbits_t rd;
        isa_pkg::word_t    data;
    } wb_t;

    // scalar view of the operand field
    typedef struct packed {
        isa_pkg::word_t rdat1;
        isa_pkg::word_t rdat2;
    } issue_sops_t;

    // gemm view, selects sit in the low bits
    typedef struct packed {
        logic [51:0]       pad;
        isa_pkg::matbits_t ms1;
        isa_pkg::matbits_t ms2;
        isa_pkg::matbits_t ms3;
    } issue_gops_t;

    // decoded by the bundle slot
    typedef union packed {
        issue_sops_t s;
        issue_gops_t g;
    } issue_ops_u;

    // registered bundle toward execute
    typedef struct packed {
        logic             valid;
        isa_pkg::slot_e   slot;
        isa_pkg::opcode_t opcode;
        issue_ops_u       ops;
    } issue_t;

    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

    // tag as seen after a same-cycle writeback, a matching producer clears it
    function automatic tag_t tag_next(tag_t tag, wb_t wb);
        if (wb.valid && tag.valid && (wb.slot == tag.slot)) begin
            return '0;
        end
        return tag;
    endfunction

endpackage

`default_nettype wire

// ==== logic/regfile.sv ====
/* regfile: scalar register file, two read ports and one write port,
   register 0 reads as zero and a same-cycle write bypasses to the reads */

`timescale 1ns/100ps
`default_nettype none

module regfile #(
    parameter int NREGS = 32
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              wen,
    input  isa_pkg::regbits_t wsel,
    input  isa_pkg::word_t    wdata,
    input  isa_pkg::regbits_t rsel1,
    input  isa_pkg::regbits_t rsel2,
    output isa_pkg::word_t    rdat1,
    output isa_pkg::word_t    rdat2
);

    isa_pkg::word_t regs [NREGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdata;
        end
    end

    // write-through so a reader in the writeback cycle sees the new value
    always_comb begin
        rdat1 = regs[rsel1];
        rdat2 = regs[rsel2];
        if (wen && (wsel == rsel1)) rdat1 = wdata;
        if (wen && (wsel == rsel2)) rdat2 = wdata;
        if (rsel1 == '0) rdat1 = '0;
        if (rsel2 == '0) rdat2 = '0;
    end

    a_wsel_range: assert property (@(posedge CLK) disable iff (!nRST)
        wen |-> (int'(wsel) < NREGS));

endmodule

`default_nettype wire

// ==== logic/fust_scalar.sv ====
/* fust_scalar: status rows for the alu, load/store and branch slots,
   written by dispatch and woken by writebacks */

`timescale 1ns/100ps
`default_nettype none

module fust_scalar (
    input  logic                              CLK,
    input  logic                              nRST,
    input  datapath_pkg::dispatch_t           dispatch,
    input  datapath_pkg::wb_t                 wb,
    output datapath_pkg::fust_s_row_t [2:0]   rows
);

    logic                      s_take;
    logic [1:0]                s_idx;
    datapath_pkg::fust_s_row_t wr_row;

    // anything that is not a matrix slot lands here
    assign s_take = dispatch.valid &&
                    (dispatch.slot != isa_pkg::SLOT_M_LD_ST) &&
                    (dispatch.slot != isa_pkg::SLOT_GEMM);
    assign s_idx  = dispatch.slot[1:0];

    // incoming row with tags already filtered through this cycle's writeback
    always_comb begin
        wr_row    = dispatch.s_row;
        wr_row.t1 = datapath_pkg::tag_next(dispatch.s_row.t1, wb);
        wr_row.t2 = datapath_pkg::tag_next(dispatch.s_row.t2, wb);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (s_take && (s_idx == 2'(i))) begin
                    rows[i] <= wr_row;
                end else begin
                    rows[i].t1 <= datapath_pkg::tag_next(rows[i].t1, wb);
                    rows[i].t2 <= datapath_pkg::tag_next(rows[i].t2, wb);
                end
            end
        end
    end

    // an out-of-range slot code would alias onto a scalar row
    a_scalar_slot: assert property (@(posedge CLK) disable iff (!nRST)
        s_take |-> (dispatch.slot inside {isa_pkg::SLOT_ALU, isa_pkg::SLOT_LD_ST,
                                          isa_pkg::SLOT_BRANCH}));

endmodule

`default_nettype wire

// ==== logic/fust_matrix.sv ====
/* fust_matrix: status rows for the matrix load/store and gemm slots,
   with per-row writes and tag clearing on writeback */

`timescale 1ns/100ps
`default_nettype none

module fust_matrix (
    input  logic                      CLK,
    input  logic                      nRST,
    input  datapath_pkg::dispatch_t   dispatch,
    input  datapath_pkg::wb_t         wb,
    output datapath_pkg::fust_g_row_t m_row,
    output datapath_pkg::fust_g_row_t g_row
);

    logic                      m_take;
    logic                      g_take;
    datapath_pkg::fust_g_row_t wr_row;

    assign m_take = dispatch.valid && (dispatch.slot == isa_pkg::SLOT_M_LD_ST);
    assign g_take = dispatch.valid && (dispatch.slot == isa_pkg::SLOT_GEMM);

    always_comb begin
        wr_row    = dispatch.g_row;
        wr_row.t1 = datapath_pkg::tag_next(dispatch.g_row.t1, wb);
        wr_row.t2 = datapath_pkg::tag_next(dispatch.g_row.t2, wb);
        wr_row.t3 = datapath_pkg::tag_next(dispatch.g_row.t3, wb);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            m_row <= '0;
            g_row <= '0;
        end else begin
            // matrix load/store has no third operand
            if (m_take) begin
                m_row     <= wr_row;
                m_row.ms3 <= '0;
                m_row.t3  <= '0;
            end else begin
                m_row.t1 <= datapath_pkg::tag_next(m_row.t1, wb);
                m_row.t2 <= datapath_pkg::tag_next(m_row.t2, wb);
            end

            if (g_take) begin
                g_row <= wr_row;
            end else begin
                g_row.t1 <= datapath_pkg::tag_next(g_row.t1, wb);
                g_row.t2 <= datapath_pkg::tag_next(g_row.t2, wb);
                g_row.t3 <= datapath_pkg::tag_next(g_row.t3, wb);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/issue.sv ====
/* scoreboard issue stage that tracks five status slots, picks the oldest
   ready row each cycle and registers its bundle toward execute */

`timescale 1ns/100ps
`default_nettype none

module issue #(
    parameter int NREGS = 32,
    parameter int AGE_W = 2
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  datapath_pkg::dispatch_t       dispatch,
    input  datapath_pkg::wb_t             wb,
    input  logic                          freeze,
    output logic [isa_pkg::NSLOTS-1:0]    busy,
    output datapath_pkg::issue_t          out
);

    localparam int NS = isa_pkg::NSLOTS;

    datapath_pkg::fust_s_row_t [2:0] s_rows;
    datapath_pkg::fust_g_row_t       m_row;
    datapath_pkg::fust_g_row_t       g_row;

    datapath_pkg::fust_state_e [NS-1:0] state;
    datapath_pkg::fust_state_e [NS-1:0] state_n;
    logic [NS-1:0][AGE_W-1:0]           age;
    logic [NS-1:0][AGE_W-1:0]           age_n;

    datapath_pkg::tag_t [NS-1:0][2:0] cur_tags;

    logic [NS-1:0]     disp_hit;
    logic [NS-1:0]     waiting;
    logic [NS-1:0]     rdy;
    logic [NS-1:0]     cand;
    logic [NS-1:0]     pick;
    logic [NS-1:0]     hold;
    logic [NS-1:0]     enter_ex;
    logic              found;
    logic [AGE_W-1:0]  best_age;
    isa_pkg::slot_e    cand_slot;
    isa_pkg::opcode_t  cand_op;

    isa_pkg::regbits_t    rsel1;
    isa_pkg::regbits_t    rsel2;
    isa_pkg::word_t       rdat1;
    isa_pkg::word_t       rdat2;
    datapath_pkg::issue_t out_n;

    regfile #(
        .NREGS(NREGS)
    ) rf_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb.valid && wb.reg_en),
        .wsel  (wb.rd),
        .wdata (wb.data),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    fust_scalar fs_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .dispatch (dispatch),
        .wb       (wb),
        .rows     (s_rows)
    );

    fust_matrix fm_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .dispatch (dispatch),
        .wb       (wb),
        .m_row    (m_row),
        .g_row    (g_row)
    );

    // readiness sees tags after this cycle's writeback
    always_comb begin
        cur_tags = '0;
        for (int i = 0; i < 3; i++) begin
            cur_tags[i][0] = datapath_pkg::tag_next(s_rows[i].t1, wb);
            cur_tags[i][1] = datapath_pkg::tag_next(s_rows[i].t2, wb);
        end
        cur_tags[3][0] = datapath_pkg::tag_next(m_row.t1, wb);
        cur_tags[3][1] = datapath_pkg::tag_next(m_row.t2, wb);
        cur_tags[4][0] = datapath_pkg::tag_next(g_row.t1, wb);
        cur_tags[4][1] = datapath_pkg::tag_next(g_row.t2, wb);
        cur_tags[4][2] = datapath_pkg::tag_next(g_row.t3, wb);

        for (int i = 0; i < NS; i++) begin
            waiting[i]  = cur_tags[i][0].valid || cur_tags[i][1].valid ||
                          cur_tags[i][2].valid;
            busy[i]     = state[i] != datapath_pkg::FUST_EMPTY;
            disp_hit[i] = dispatch.valid && (dispatch.slot == isa_pkg::slot_e'(3'(i)));
            rdy[i]      = ((state[i] == datapath_pkg::FUST_WAIT) ||
                           (state[i] == datapath_pkg::FUST_RDY)) && !waiting[i];
        end
    end

    // oldest ready wins
    // a strict compare keeps the lowest slot on a tie
    always_comb begin
        cand      = '0;
        found     = 1'b0;
        best_age  = '0;
        cand_slot = isa_pkg::SLOT_ALU;
        for (int i = 0; i < NS; i++) begin
            if (rdy[i] && (!found || (age[i] > best_age))) begin
                found     = 1'b1;
                best_age  = age[i];
                cand      = '0;
                cand[i]   = 1'b1;
                cand_slot = isa_pkg::slot_e'(3'(i));
            end
        end
        pick = freeze ? '0 : cand;
        hold = freeze ? cand : '0;
    end

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            state_n[i] = state[i];
            age_n[i]   = '0;
            case (state[i])
                datapath_pkg::FUST_EMPTY: begin
                    if (disp_hit[i]) state_n[i] = datapath_pkg::FUST_WAIT;
                end
                datapath_pkg::FUST_WAIT, datapath_pkg::FUST_RDY: begin
                    if (pick[i]) begin
                        state_n[i] = datapath_pkg::FUST_EX;
                    end else if (hold[i]) begin
                        age_n[i] = age[i];
                    end else begin
                        if (rdy[i]) state_n[i] = datapath_pkg::FUST_RDY;
                        // saturate at the top age
                        age_n[i] = (age[i] == '1) ? age[i] : age[i] + 1'b1;
                    end
                end
                datapath_pkg::FUST_EX: begin
                    if (wb.valid && (wb.slot == isa_pkg::slot_e'(3'(i)))) begin
                        state_n[i] = datapath_pkg::FUST_EMPTY;
                    end
                end
                default: state_n[i] = datapath_pkg::FUST_EMPTY;
            endcase
            enter_ex[i] = (state[i] != datapath_pkg::FUST_EX) &&
                          (state_n[i] == datapath_pkg::FUST_EX);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= {NS{datapath_pkg::FUST_EMPTY}};
            age   <= '0;
        end else begin
            state <= state_n;
            age   <= age_n;
        end
    end

    // operand selects follow the candidate row
    // matrix load/store uses ms1/ms2 as scalar base and offset registers
    always_comb begin
        rsel1   = '0;
        rsel2   = '0;
        cand_op = '0;
        case (cand_slot)
            isa_pkg::SLOT_ALU, isa_pkg::SLOT_LD_ST, isa_pkg::SLOT_BRANCH: begin
                rsel1   = s_rows[cand_slot[1:0]].rs1;
                rsel2   = s_rows[cand_slot[1:0]].rs2;
                cand_op = s_rows[cand_slot[1:0]].opcode;
            end
            isa_pkg::SLOT_M_LD_ST: begin
                rsel1   = {1'b0, m_row.ms1};
                rsel2   = {1'b0, m_row.ms2};
                cand_op = m_row.opcode;
            end
            isa_pkg::SLOT_GEMM: cand_op = g_row.opcode;
            default: cand_op = '0;
        endcase
    end

    always_comb begin
        out_n = '0;
        if (|pick) begin
            out_n.valid  = 1'b1;
            out_n.slot   = cand_slot;
            out_n.opcode = cand_op;
            if (cand_slot == isa_pkg::SLOT_GEMM) begin
                out_n.ops.g.pad = '0;
                out_n.ops.g.ms1 = g_row.ms1;
                out_n.ops.g.ms2 = g_row.ms2;
                out_n.ops.g.ms3 = g_row.ms3;
            end else begin
                out_n.ops.s.rdat1 = rdat1;
                out_n.ops.s.rdat2 = rdat2;
            end
        end
    end

    // freeze holds the bundle toward execute
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else if (!freeze) begin
            out <= out_n;
        end
    end

    a_disp_free: assert property (@(posedge CLK) disable iff (!nRST)
        dispatch.valid |-> (dispatch.slot <= isa_pkg::SLOT_GEMM) && !busy[dispatch.slot]);

    a_one_issue: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(enter_ex));

    // nothing enters execute in a frozen cycle and the held bundle stays put
    a_freeze_hold: assert property (@(posedge CLK) disable iff (!nRST)
        freeze |-> (enter_ex == '0) ##1 $stable(out));

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
/* tb_clock: free-running testbench clock */

`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD = 4.0
) (
    output logic CLK
);

    initial CLK = 1'b0;

    always #(PERIOD / 2.0) CLK = ~CLK;

endmodule

`default_nettype wire

// ==== tb/issue_tb.sv ====
/* issue_tb: table-driven testbench for the scoreboard issue stage,
   a reference scoreboard predicts busy and every issued bundle */

`timescale 1ns/100ps
`default_nettype none

module issue_tb;

    localparam int NREGS   = 32;
    localparam int AGE_W   = 2;
    localparam int AGE_MAX = (1 << AGE_W) - 1;
    localparam int NS      = 5;
    localparam int TIMEOUT = 20;

    // slot codes used in the table, NO marks an unused entry
    localparam int NO = -1;
    localparam int SA = 0;
    localparam int SL = 1;
    localparam int SB = 2;
    localparam int SM = 3;
    localparam int SG = 4;

    // reference slot states
    localparam int EMPTY   = 0;
    localparam int WAITING = 1;
    localparam int RUNNING = 2;

    typedef struct {
        int d_slot;
        int op;
        int a;
        int b;
        int c;
        int t1;
        int t2;
        int t3;
        int w_slot;
        int w_rd;
        bit frz;
        int exp_slot;
        int exp_lat;
    } step_t;

    logic                    CLK;
    logic                    nRST;
    datapath_pkg::dispatch_t dispatch;
    datapath_pkg::wb_t       wb;
    logic                    freeze;
    logic [NS-1:0]           busy;
    datapath_pkg::issue_t    iss_out;

    step_t steps [$];
    step_t idle;
    int    errors;
    int    checks;

    // reference scoreboard
    int                   st [NS];
    int                   age [NS];
    bit                   tv [NS][3];
    int                   ts [NS][3];
    int                   row_op [NS];
    int                   row_a [NS];
    int                   row_b [NS];
    int                   row_c [NS];
    isa_pkg::word_t       ref_regs [NREGS];
    datapath_pkg::issue_t exp_out;
    logic [NS-1:0]        exp_busy;

    tb_clock #(
        .PERIOD(4.0)
    ) clk_i (
        .CLK(CLK)
    );

    issue #(
        .NREGS(NREGS),
        .AGE_W(AGE_W)
    ) dut_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .dispatch (dispatch),
        .wb       (wb),
        .freeze   (freeze),
        .busy     (busy),
        .out      (iss_out)
    );

    task automatic push_step(input int d_slot, op, a, b, c, t1, t2, t3,
                             input int w_slot, w_rd, input bit frz,
                             input int exp_slot, exp_lat);
        step_t s;
        s = '{d_slot, op, a, b, c, t1, t2, t3, w_slot, w_rd, frz, exp_slot, exp_lat};
        steps.push_back(s);
    endtask

    function automatic datapath_pkg::tag_t make_tag(input int t);
        datapath_pkg::tag_t tag;
        tag = '0;
        if (t >= 0) begin
            tag.valid = 1'b1;
            tag.slot  = isa_pkg::slot_e'(3'(t));
        end
        return tag;
    endfunction

    // register read as execute should see it, new data wins in the write cycle
    function automatic isa_pkg::word_t read_reg(input int r, input step_t s,
                                                input isa_pkg::word_t data);
        if (r == 0) return '0;
        if ((s.w_slot >= 0) && (s.w_rd == r)) return data;
        return ref_regs[r];
    endfunction

    task automatic drive_inputs(input step_t s, input isa_pkg::word_t data);
        dispatch = '0;
        wb       = '0;
        if (s.d_slot >= 0) begin
            dispatch.valid        = 1'b1;
            dispatch.slot         = isa_pkg::slot_e'(3'(s.d_slot));
            dispatch.s_row.opcode = 6'(s.op);
            dispatch.s_row.rd     = 5'(s.c);
            dispatch.s_row.rs1    = 5'(s.a);
            dispatch.s_row.rs2    = 5'(s.b);
            dispatch.s_row.t1     = make_tag(s.t1);
            dispatch.s_row.t2     = make_tag(s.t2);
            dispatch.g_row.opcode = 6'(s.op);
            dispatch.g_row.ms1    = 4'(s.a);
            dispatch.g_row.ms2    = 4'(s.b);
            dispatch.g_row.ms3    = 4'(s.c);
            dispatch.g_row.t1     = make_tag(s.t1);
            dispatch.g_row.t2     = make_tag(s.t2);
            dispatch.g_row.t3     = make_tag(s.t3);
        end
        if (s.w_slot >= 0) begin
            wb.valid  = 1'b1;
            wb.slot   = isa_pkg::slot_e'(3'(s.w_slot));
            wb.reg_en = (s.w_rd != 0);
            wb.rd     = 5'(s.w_rd);
            wb.data   = data;
        end
        freeze = s.frz;
    endtask

    // advance the reference by one clock with this cycle's inputs
    task automatic model_cycle(input step_t s, input isa_pkg::word_t data);
        int cand;
        int best;
        bit rdy;
        cand = -1;
        best = -1;
        for (int i = 0; i < NS; i++) begin
            for (int k = 0; k < 3; k++) begin
                if ((s.w_slot >= 0) && (ts[i][k] == s.w_slot)) tv[i][k] = 1'b0;
            end
        end
        // oldest ready row, first one found keeps a tie
        for (int i = 0; i < NS; i++) begin
            rdy = (st[i] == WAITING) && !tv[i][0] && !tv[i][1] && !tv[i][2];
            if (rdy && (age[i] > best)) begin
                cand = i;
                best = age[i];
            end
        end
        if (!s.frz) begin
            exp_out = '0;
            if (cand >= 0) begin
                exp_out.valid  = 1'b1;
                exp_out.slot   = isa_pkg::slot_e'(3'(cand));
                exp_out.opcode = 6'(row_op[cand]);
                if (cand == SG) begin
                    exp_out.ops.g.ms1 = 4'(row_a[cand]);
                    exp_out.ops.g.ms2 = 4'(row_b[cand]);
                    exp_out.ops.g.ms3 = 4'(row_c[cand]);
                end else begin
                    exp_out.ops.s.rdat1 = read_reg(row_a[cand], s, data);
                    exp_out.ops.s.rdat2 = read_reg(row_b[cand], s, data);
                end
            end
        end
        for (int i = 0; i < NS; i++) begin
            case (st[i])
                EMPTY: begin
                    if (s.d_slot == i) begin
                        st[i]     = WAITING;
                        age[i]    = 0;
                        row_op[i] = s.op;
                        row_a[i]  = s.a;
                        row_b[i]  = s.b;
                        row_c[i]  = s.c;
                        ts[i][0]  = s.t1;
                        ts[i][1]  = s.t2;
                        ts[i][2]  = s.t3;
                        for (int k = 0; k < 3; k++) begin
                            tv[i][k] = (ts[i][k] >= 0) && (ts[i][k] != s.w_slot);
                        end
                    end
                end
                WAITING: begin
                    if ((i == cand) && !s.frz) begin
                        st[i]  = RUNNING;
                        age[i] = 0;
                    end else if (i != cand) begin
                        age[i] = (age[i] < AGE_MAX) ? age[i] + 1 : AGE_MAX;
                    end
                end
                default: begin
                    if (s.w_slot == i) st[i] = EMPTY;
                end
            endcase
            exp_busy[i] = (st[i] != EMPTY);
        end
        if ((s.w_slot >= 0) && (s.w_rd != 0)) ref_regs[s.w_rd] = data;
    endtask

    task automatic check_outputs();
        checks++;
        if (busy !== exp_busy) begin
            $display("error at %0t ns: busy = %b, expected %b", $time, busy, exp_busy);
            errors++;
        end
        if (iss_out !== exp_out) begin
            $display("error at %0t ns: out = %h, expected %h", $time, iss_out, exp_out);
            errors++;
        end
    endtask

    // one clock: drive after the edge, compare after the next edge
    task automatic run_cycle(input step_t s);
        isa_pkg::word_t data;
        data = $urandom();
        drive_inputs(s, data);
        model_cycle(s, data);
        @(posedge CLK);
        #1;
        check_outputs();
    endtask

    task automatic wait_issue(input int slot, input int lat);
        int n;
        n = 0;
        while (!(iss_out.valid && (int'(iss_out.slot) == slot)) && (n < TIMEOUT)) begin
            run_cycle(idle);
            n++;
        end
        if (!(iss_out.valid && (int'(iss_out.slot) == slot))) begin
            $display("timeout at %0t ns: slot %0d did not issue within %0d cycles",
                     $time, slot, TIMEOUT);
            errors++;
        end else if ((lat > 0) && (n != lat)) begin
            $display("error at %0t ns: issue latency of slot %0d = %0d, expected %0d",
                     $time, slot, n, lat);
            errors++;
        end
    endtask

    initial begin
        nRST     = 1'b0;
        dispatch = '0;
        wb       = '0;
        freeze   = 1'b0;
        errors   = 0;
        checks   = 0;
        exp_out  = '0;
        exp_busy = '0;
        idle     = '{NO, 0, 0, 0, 0, NO, NO, NO, NO, 0, 1'b0, NO, 0};
        for (int r = 0; r < NREGS; r++) begin
            ref_regs[r] = '0;
        end
        void'($urandom(32'h107b_883b));

        // d_slot op a b c(rd/ms3) t1 t2 t3 | w_slot w_rd | frz | exp_slot exp_lat
        // preload registers 1 to 4, then an independent alu
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 1, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 2, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 3, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 4, 0, NO, 0);
        push_step(SA, 1, 1, 2, 0, NO, NO, NO, NO, 0, 0, SA, 1);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 5, 0, NO, 0);
        // load/store waits on the alu result in r6
        push_step(SA, 2, 3, 4, 6, NO, NO, NO, NO, 0, 0, SA, 1);
        push_step(SL, 3, 6, 1, 0, SA, NO, NO, NO, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, NO, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 6, 0, SL, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SL, 0, 0, NO, 0);
        // three rows wake together, oldest first even from a higher slot
        push_step(SA, 4, 1, 2, 7, NO, NO, NO, NO, 0, 0, SA, 1);
        push_step(SM, 8, 7, 3, 0, SA, NO, NO, NO, 0, 0, NO, 0);
        push_step(SB, 6, 7, 1, 0, SA, NO, NO, NO, 0, 0, NO, 0);
        push_step(SL, 5, 2, 7, 0, NO, SA, NO, NO, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, NO, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 7, 0, SM, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SM, 0, 0, SB, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SB, 0, 0, SL, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SL, 0, 0, NO, 0);
        // saturated ages tie, the lower slot goes first
        push_step(SA, 9, 3, 4, 8, NO, NO, NO, NO, 0, 0, SA, 1);
        push_step(SB, 10, 8, 2, 0, SA, NO, NO, NO, 0, 0, NO, 0);
        push_step(SL, 11, 1, 8, 0, NO, SA, NO, NO, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, NO, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, NO, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, NO, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 8, 0, SL, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SL, 0, 0, SB, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SB, 0, 0, NO, 0);
        // freeze holds the alu bundle while the load/store wakes
        push_step(SA, 12, 5, 6, 9, NO, NO, NO, NO, 0, 0, SA, 1);
        push_step(SL, 13, 9, 0, 0, SA, NO, NO, NO, 0, 1, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 9, 1, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, NO, 0, 1, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, NO, 0, 0, SL, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SL, 0, 0, NO, 0);
        // gemm waits on three producers
        push_step(SA, 14, 1, 1, 10, NO, NO, NO, NO, 0, 0, SA, 1);
        push_step(SL, 15, 2, 2, 0, NO, NO, NO, NO, 0, 0, SL, 1);
        push_step(SB, 16, 3, 3, 0, NO, NO, NO, NO, 0, 0, SB, 1);
        push_step(SG, 17, 5, 6, 7, SA, SL, SB, NO, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SA, 10, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SL, 0, 0, NO, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SB, 0, 0, SG, 0);
        push_step(NO, 0, 0, 0, 0, NO, NO, NO, SG, 0, 0, NO, 0);

        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;
        check_outputs();

        foreach (steps[i]) begin
            run_cycle(steps[i]);
            if (steps[i].exp_slot >= 0) begin
                wait_issue(steps[i].exp_slot, steps[i].exp_lat);
            end
        end
        run_cycle(idle);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/isa_pkg.sv
logic/datapath_pkg.sv
logic/regfile.sv
logic/fust_scalar.sv
logic/fust_matrix.sv
logic/issue.sv
tb/tb_clock.sv
tb/issue_tb.sv

// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - files:
      - logic/isa_pkg.sv
      - logic/datapath_pkg.sv
      - logic/regfile.sv
      - logic/fust_scalar.sv
      - logic/fust_matrix.sv
      - logic/issue.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/issue_tb.sv
